// ==== Makefile ====
# Verilator build and run for the RAM model testbench.

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module rammodel_tb \
		-Mdir obj_dir -f sim.f

run: compile
	./obj_dir/Vrammodel_tb

clean:
	rm -rf obj_dir

// ==== design/rammodel_backend.sv ====
`timescale 1ns/1ps

module rammodel_backend
    import rammodel_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_awreq_valid,
    input  axi_a_t                i_awreq,
    input  logic                  i_wreq_valid,
    input  axi_w_t                i_wreq,
    input  logic                  i_arreq_valid,
    input  axi_a_t                i_arreq,
    input  logic                  i_rreq_valid,
    output logic [DATA_WIDTH-1:0] o_rresp_data
);

    logic [DATA_WIDTH-1:0]  mem      [MEM_WORDS];

    logic [WORD_BITS-1:0]   wq_word  [BE_DEPTH];
    logic [1:0]             wq_burst [BE_DEPTH];
    logic [BE_PTR_BITS-1:0] wq_wr;
    logic [BE_PTR_BITS-1:0] wq_rd;
    logic                   w_first;
    logic [WORD_BITS-1:0]   w_cur;
    logic [WORD_BITS-1:0]   w_word;

    logic [WORD_BITS-1:0]   rq_word  [BE_DEPTH];
    logic [7:0]             rq_len   [BE_DEPTH];
    logic [1:0]             rq_burst [BE_DEPTH];
    logic [BE_PTR_BITS-1:0] rq_wr;
    logic [BE_PTR_BITS-1:0] rq_rd;
    logic                   r_first;
    logic [WORD_BITS-1:0]   r_cur;
    logic [WORD_BITS-1:0]   r_word;
    logic [7:0]             r_beat;

    function automatic logic [WORD_BITS-1:0] next_word(
        input logic [WORD_BITS-1:0] word,
        input logic [1:0]           burst
    );
        case (burst)
            BURST_INCR:  return word + WORD_BITS'(1);
            BURST_FIXED: return word;
            default:     return word;
        endcase
    endfunction

    // First beat of a burst takes its word from the queue head.
    assign w_word       = w_first ? wq_word[wq_rd] : w_cur;
    assign r_word       = r_first ? rq_word[rq_rd] : r_cur;
    assign o_rresp_data = mem[r_word];

    always_ff @(posedge clk) begin
        if (i_awreq_valid) begin
            wq_word[wq_wr]  <= i_awreq.addr[BYTE_BITS +: WORD_BITS];
            wq_burst[wq_wr] <= i_awreq.burst;
        end
        if (i_arreq_valid) begin
            rq_word[rq_wr]  <= i_arreq.addr[BYTE_BITS +: WORD_BITS];
            rq_len[rq_wr]   <= i_arreq.len;
            rq_burst[rq_wr] <= i_arreq.burst;
        end
        if (i_wreq_valid) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (i_wreq.strb[b]) begin
                    mem[w_word][8*b +: 8] <= i_wreq.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wq_wr   <= '0;
            wq_rd   <= '0;
            w_first <= 1'b1;
            rq_wr   <= '0;
            rq_rd   <= '0;
            r_first <= 1'b1;
            r_beat  <= '0;
        end else begin
            wq_wr <= wq_wr + BE_PTR_BITS'(i_awreq_valid);
            rq_wr <= rq_wr + BE_PTR_BITS'(i_arreq_valid);
            if (i_wreq_valid) begin
                w_first <= i_wreq.last;
                w_cur   <= next_word(w_word, wq_burst[wq_rd]);
                wq_rd   <= wq_rd + BE_PTR_BITS'(i_wreq.last);
            end
            if (i_rreq_valid) begin
                r_cur <= next_word(r_word, rq_burst[rq_rd]);
                if (r_beat == rq_len[rq_rd]) begin    // Final beat of the burst.
                    r_first <= 1'b1;
                    r_beat  <= '0;
                    rq_rd   <= rq_rd + BE_PTR_BITS'(1);
                end else begin
                    r_first <= 1'b0;
                    r_beat  <= r_beat + 8'd1;
                end
            end
        end
    end

endmodule

// ==== design/rammodel_fork.sv ====
`timescale 1ns/1ps

module rammodel_fork #(
    parameter int BRANCHES = 2
) (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_valid,
    output logic                o_ready,
    output logic [BRANCHES-1:0] o_valid,
    input  logic [BRANCHES-1:0] i_ready
);

    logic [BRANCHES-1:0] taken;
    logic [BRANCHES-1:0] taken_next;

    assign o_valid    = {BRANCHES{i_valid}} & ~taken;
    assign taken_next = taken | (o_valid & i_ready);
    assign o_ready    = &(taken | i_ready);    // All branches done, now or before.

    always_ff @(posedge clk) begin
        if (i_reset) begin
            taken <= '0;
        end else if (i_valid && o_ready) begin
            taken <= '0;                       // Upstream transfer completes.
        end else begin
            taken <= taken_next;
        end
    end

endmodule

// ==== design/rammodel_frontend.sv ====
`timescale 1ns/1ps

module rammodel_frontend
    import rammodel_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_reset,
    input  axi_a_t                i_aw,
    input  logic                  i_aw_valid,
    output logic                  o_aw_ready,
    input  axi_w_t                i_w,
    input  logic                  i_w_valid,
    output logic                  o_w_ready,
    input  axi_a_t                i_ar,
    input  logic                  i_ar_valid,
    output logic                  o_ar_ready,
    output axi_b_t                o_b,
    output logic                  o_b_valid,
    input  logic                  i_b_ready,
    output axi_r_t                o_r,
    output logic                  o_r_valid,
    input  logic                  i_r_ready,
    output logic                  o_awreq_valid,
    output axi_a_t                o_awreq,
    output logic                  o_wreq_valid,
    output axi_w_t                o_wreq,
    output logic                  o_arreq_valid,
    output axi_a_t                o_arreq,
    output logic                  o_rreq_valid,
    input  logic [DATA_WIDTH-1:0] i_rresp_data
);

    logic                tm_aw_valid;
    logic                tm_aw_ready;
    logic                tm_w_valid;
    logic                tm_w_ready;
    logic                tm_ar_valid;
    logic                tm_ar_ready;
    logic                trk_aw_valid;
    logic                trk_aw_ready;
    logic                trk_ar_valid;
    logic                trk_ar_ready;
    logic [ID_WIDTH-1:0] tm_r_id;
    logic                tm_r_last;
    logic                w_fork_valid;

    // W reaches storage only once its AW is known to the timing model.
    assign w_fork_valid = i_w_valid && tm_w_ready;

    rammodel_fork #(.BRANCHES(3)) fork_aw_i (
        .clk     (clk),
        .i_reset (i_reset),
        .i_valid (i_aw_valid),
        .o_ready (o_aw_ready),
        .o_valid ({trk_aw_valid, tm_aw_valid, o_awreq_valid}),
        .i_ready ({trk_aw_ready, tm_aw_ready, 1'b1})
    );

    rammodel_fork #(.BRANCHES(2)) fork_w_i (
        .clk     (clk),
        .i_reset (i_reset),
        .i_valid (w_fork_valid),
        .o_ready (o_w_ready),
        .o_valid ({tm_w_valid, o_wreq_valid}),
        .i_ready ({tm_w_ready, 1'b1})
    );

    rammodel_fork #(.BRANCHES(3)) fork_ar_i (
        .clk     (clk),
        .i_reset (i_reset),
        .i_valid (i_ar_valid),
        .o_ready (o_ar_ready),
        .o_valid ({trk_ar_valid, tm_ar_valid, o_arreq_valid}),
        .i_ready ({trk_ar_ready, tm_ar_ready, 1'b1})
    );

    assign o_awreq = i_aw;
    assign o_wreq  = i_w;
    assign o_arreq = i_ar;

    rammodel_tracker tracker_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_ar_valid (trk_ar_valid),
        .o_ar_ready (trk_ar_ready),
        .i_aw_valid (trk_aw_valid),
        .o_aw_ready (trk_aw_ready),
        .i_r_done   (o_rreq_valid && tm_r_last),
        .i_b_done   (o_b_valid && i_b_ready)
    );

    rammodel_timing_model timing_model_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_ar       (i_ar),
        .i_ar_valid (tm_ar_valid),
        .o_ar_ready (tm_ar_ready),
        .i_aw       (i_aw),
        .i_aw_valid (tm_aw_valid),
        .o_aw_ready (tm_aw_ready),
        .i_w_last   (i_w.last),
        .i_w_valid  (tm_w_valid),
        .o_w_ready  (tm_w_ready),
        .o_b        (o_b),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .o_r_id     (tm_r_id),
        .o_r_last   (tm_r_last),
        .o_r_valid  (o_r_valid),
        .i_r_ready  (i_r_ready)
    );

    assign o_rreq_valid = o_r_valid && i_r_ready;    // Steps the back-end read pointer.
    assign o_r = '{id: tm_r_id, data: i_rresp_data, resp: RESP_OKAY, last: tm_r_last};

endmodule

// ==== design/rammodel_pkg.sv ====
package rammodel_pkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 64;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;
    localparam int ID_WIDTH       = 4;

    localparam int MAX_R_INFLIGHT = 4;
    localparam int MAX_W_INFLIGHT = 4;
    localparam int READ_LATENCY   = 8;
    localparam int WRITE_LATENCY  = 4;
    localparam int TIME_WIDTH     = 32;

    localparam int R_PTR_BITS     = $clog2(MAX_R_INFLIGHT);
    localparam int R_CNT_BITS     = $clog2(MAX_R_INFLIGHT + 1);
    localparam int W_PTR_BITS     = $clog2(MAX_W_INFLIGHT);
    localparam int W_CNT_BITS     = $clog2(MAX_W_INFLIGHT + 1);

    localparam int MEM_WORDS      = 256;
    localparam int WORD_BITS      = $clog2(MEM_WORDS);
    localparam int BYTE_BITS      = $clog2(STRB_WIDTH);
    localparam int BE_DEPTH       = 8;    // Room for one request still held in a fork.
    localparam int BE_PTR_BITS    = $clog2(BE_DEPTH);

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] RESP_OKAY   = 2'd0;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;     // Beats minus one.
        logic [1:0]            burst;
    } axi_a_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [1:0]            resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

endpackage

// ==== design/rammodel_timing_model.sv ====
`timescale 1ns/1ps

module rammodel_timing_model
    import rammodel_pkg::*;
(
    input  logic                clk,
    input  logic                i_reset,
    input  axi_a_t              i_ar,
    input  logic                i_ar_valid,
    output logic                o_ar_ready,
    input  axi_a_t              i_aw,
    input  logic                i_aw_valid,
    output logic                o_aw_ready,
    input  logic                i_w_last,
    input  logic                i_w_valid,
    output logic                o_w_ready,
    output axi_b_t              o_b,
    output logic                o_b_valid,
    input  logic                i_b_ready,
    output logic [ID_WIDTH-1:0] o_r_id,
    output logic                o_r_last,
    output logic                o_r_valid,
    input  logic                i_r_ready
);

    logic [TIME_WIDTH-1:0] now;

    logic [ID_WIDTH-1:0]   rq_id  [MAX_R_INFLIGHT];
    logic [7:0]            rq_len [MAX_R_INFLIGHT];
    logic [TIME_WIDTH-1:0] rq_due [MAX_R_INFLIGHT];
    logic [R_PTR_BITS-1:0] rq_wr;
    logic [R_PTR_BITS-1:0] rq_rd;
    logic [R_CNT_BITS-1:0] rq_count;
    logic [7:0]            r_beat;

    logic [ID_WIDTH-1:0]   aq_id  [MAX_W_INFLIGHT];
    logic [W_PTR_BITS-1:0] aq_wr;
    logic [W_PTR_BITS-1:0] aq_rd;
    logic [W_CNT_BITS-1:0] aq_count;
    logic [ID_WIDTH-1:0]   bq_id  [MAX_W_INFLIGHT];
    logic [TIME_WIDTH-1:0] bq_due [MAX_W_INFLIGHT];
    logic [W_PTR_BITS-1:0] bq_wr;
    logic [W_PTR_BITS-1:0] bq_rd;
    logic [W_CNT_BITS-1:0] bq_count;
    logic [W_CNT_BITS:0]   w_busy;

    logic ar_take;
    logic r_take;
    logic r_pop;
    logic aw_take;
    logic w_done;
    logic b_take;

    function automatic logic is_due(
        input logic [TIME_WIDTH-1:0] t_now,
        input logic [TIME_WIDTH-1:0] t_due
    );
        logic [TIME_WIDTH-1:0] diff;
        diff = t_now - t_due;
        return !diff[TIME_WIDTH-1];    // Survives counter wrap.
    endfunction

    assign o_ar_ready = (rq_count != R_CNT_BITS'(MAX_R_INFLIGHT));
    assign ar_take    = i_ar_valid && o_ar_ready;
    assign o_r_valid  = (rq_count != '0) && is_due(now, rq_due[rq_rd]);
    assign o_r_id     = rq_id[rq_rd];
    assign o_r_last   = (r_beat == rq_len[rq_rd]);
    assign r_take     = o_r_valid && i_r_ready;
    assign r_pop      = r_take && o_r_last;

    // Writes waiting for data plus writes waiting for B share one budget.
    assign w_busy     = {1'b0, aq_count} + {1'b0, bq_count};
    assign o_aw_ready = (w_busy < (W_CNT_BITS + 1)'(MAX_W_INFLIGHT));
    assign aw_take    = i_aw_valid && o_aw_ready;
    assign o_w_ready  = (aq_count != '0);
    assign w_done     = i_w_valid && o_w_ready && i_w_last;
    assign o_b_valid  = (bq_count != '0) && is_due(now, bq_due[bq_rd]);
    assign o_b        = '{id: bq_id[bq_rd], resp: RESP_OKAY};
    assign b_take     = o_b_valid && i_b_ready;

    always_ff @(posedge clk) begin
        if (ar_take) begin
            rq_id[rq_wr]  <= i_ar.id;
            rq_len[rq_wr] <= i_ar.len;
            rq_due[rq_wr] <= now + TIME_WIDTH'(READ_LATENCY);
        end
        if (aw_take) begin
            aq_id[aq_wr] <= i_aw.id;
        end
        if (w_done) begin
            bq_id[bq_wr]  <= aq_id[aq_rd];
            bq_due[bq_wr] <= now + TIME_WIDTH'(WRITE_LATENCY);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            now      <= '0;
            rq_wr    <= '0;
            rq_rd    <= '0;
            rq_count <= '0;
            r_beat   <= '0;
            aq_wr    <= '0;
            aq_rd    <= '0;
            aq_count <= '0;
            bq_wr    <= '0;
            bq_rd    <= '0;
            bq_count <= '0;
        end else begin
            now      <= now + TIME_WIDTH'(1);
            rq_wr    <= rq_wr + R_PTR_BITS'(ar_take);
            rq_rd    <= rq_rd + R_PTR_BITS'(r_pop);
            rq_count <= rq_count + R_CNT_BITS'(ar_take) - R_CNT_BITS'(r_pop);
            r_beat   <= r_pop ? 8'd0 : r_beat + 8'(r_take);
            aq_wr    <= aq_wr + W_PTR_BITS'(aw_take);
            aq_rd    <= aq_rd + W_PTR_BITS'(w_done);
            aq_count <= aq_count + W_CNT_BITS'(aw_take) - W_CNT_BITS'(w_done);
            bq_wr    <= bq_wr + W_PTR_BITS'(w_done);
            bq_rd    <= bq_rd + W_PTR_BITS'(b_take);
            bq_count <= bq_count + W_CNT_BITS'(w_done) - W_CNT_BITS'(b_take);
        end
    end

endmodule

// ==== design/rammodel_top.sv ====
`timescale 1ns/1ps

module rammodel_top
    import rammodel_pkg::*;
(
    input  logic   clk,
    input  logic   i_reset,
    input  axi_a_t i_aw,
    input  logic   i_aw_valid,
    output logic   o_aw_ready,
    input  axi_w_t i_w,
    input  logic   i_w_valid,
    output logic   o_w_ready,
    input  axi_a_t i_ar,
    input  logic   i_ar_valid,
    output logic   o_ar_ready,
    output axi_b_t o_b,
    output logic   o_b_valid,
    input  logic   i_b_ready,
    output axi_r_t o_r,
    output logic   o_r_valid,
    input  logic   i_r_ready
);

    logic                  awreq_valid;
    axi_a_t                awreq;
    logic                  wreq_valid;
    axi_w_t                wreq;
    logic                  arreq_valid;
    axi_a_t                arreq;
    logic                  rreq_valid;
    logic [DATA_WIDTH-1:0] rresp_data;

    rammodel_frontend frontend_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_aw          (i_aw),
        .i_aw_valid    (i_aw_valid),
        .o_aw_ready    (o_aw_ready),
        .i_w           (i_w),
        .i_w_valid     (i_w_valid),
        .o_w_ready     (o_w_ready),
        .i_ar          (i_ar),
        .i_ar_valid    (i_ar_valid),
        .o_ar_ready    (o_ar_ready),
        .o_b           (o_b),
        .o_b_valid     (o_b_valid),
        .i_b_ready     (i_b_ready),
        .o_r           (o_r),
        .o_r_valid     (o_r_valid),
        .i_r_ready     (i_r_ready),
        .o_awreq_valid (awreq_valid),
        .o_awreq       (awreq),
        .o_wreq_valid  (wreq_valid),
        .o_wreq        (wreq),
        .o_arreq_valid (arreq_valid),
        .o_arreq       (arreq),
        .o_rreq_valid  (rreq_valid),
        .i_rresp_data  (rresp_data)
    );

    rammodel_backend backend_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_awreq_valid (awreq_valid),
        .i_awreq       (awreq),
        .i_wreq_valid  (wreq_valid),
        .i_wreq        (wreq),
        .i_arreq_valid (arreq_valid),
        .i_arreq       (arreq),
        .i_rreq_valid  (rreq_valid),
        .o_rresp_data  (rresp_data)
    );

endmodule

// ==== design/rammodel_tracker.sv ====
`timescale 1ns/1ps

module rammodel_tracker
    import rammodel_pkg::*;
(
    input  logic clk,
    input  logic i_reset,
    input  logic i_ar_valid,
    output logic o_ar_ready,
    input  logic i_aw_valid,
    output logic o_aw_ready,
    input  logic i_r_done,
    input  logic i_b_done
);

    logic [R_CNT_BITS-1:0] r_count;
    logic [W_CNT_BITS-1:0] w_count;
    logic                  ar_take;
    logic                  aw_take;

    // Registered counts, so a limit shows one cycle later.
    assign o_ar_ready = (r_count != R_CNT_BITS'(MAX_R_INFLIGHT));
    assign o_aw_ready = (w_count != W_CNT_BITS'(MAX_W_INFLIGHT));

    assign ar_take = i_ar_valid && o_ar_ready;
    assign aw_take = i_aw_valid && o_aw_ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            r_count <= '0;
        end else if (ar_take && !i_r_done) begin
            r_count <= r_count + R_CNT_BITS'(1);
        end else if (!ar_take && i_r_done) begin
            r_count <= r_count - R_CNT_BITS'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            w_count <= '0;
        end else if (aw_take && !i_b_done) begin
            w_count <= w_count + W_CNT_BITS'(1);
        end else if (!aw_take && i_b_done) begin
            w_count <= w_count - W_CNT_BITS'(1);
        end
    end

endmodule

// ==== sim.f ====
design/rammodel_pkg.sv
design/rammodel_fork.sv
design/rammodel_tracker.sv
design/rammodel_timing_model.sv
design/rammodel_frontend.sv
design/rammodel_backend.sv
design/rammodel_top.sv
tests/rammodel_tb.sv

// ==== tests/rammodel_tb.sv ====
`timescale 1ns/1ps

module rammodel_tb
    import rammodel_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 6000;    // Fill, directed tests and 40 random ops.

    typedef struct packed {
        axi_r_t      r;
        logic        first;
        logic [31:0] cyc;
    } exp_r_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [31:0]         cyc;
    } exp_b_t;

    logic   clk = 1'b0;
    logic   i_reset;
    axi_a_t i_aw;
    logic   i_aw_valid;
    logic   o_aw_ready;
    axi_w_t i_w;
    logic   i_w_valid;
    logic   o_w_ready;
    axi_a_t i_ar;
    logic   i_ar_valid;
    logic   o_ar_ready;
    axi_b_t o_b;
    logic   o_b_valid;
    logic   i_b_ready;
    axi_r_t o_r;
    logic   o_r_valid;
    logic   i_r_ready;

    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    exp_r_t                exp_r[$];
    exp_b_t                exp_b[$];
    logic [31:0]           cycle = '0;
    logic [15:0]           data_lfsr;
    logic [15:0]           ready_lfsr;
    logic                  r_hold;
    logic                  bp_on;

    rammodel_top dut_i (.*);

    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            v[i] = data_lfsr[0];
        end
    endtask

    task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_text("Timeout, the run did not finish in time.");
        end
    end

    // Three of four cycles ready under back-pressure.
    always @(posedge clk) begin
        logic a;
        logic b;
        ready_lfsr = lfsr_next(ready_lfsr);
        a = ready_lfsr[0];
        ready_lfsr = lfsr_next(ready_lfsr);
        b = ready_lfsr[0];
        i_b_ready <= !bp_on || a || b;
        i_r_ready <= !r_hold && (!bp_on || a || b);
    end

    // Responses are checked mid-cycle before their handshake edge.
    always @(negedge clk) begin
        exp_r_t er;
        exp_b_t eb;
        if (!i_reset && o_r_valid) begin
            assert (exp_r.size() != 0) else fail_text("R valid with no read outstanding.");
            er = exp_r[0];
            if (er.first) begin
                assert (cycle - er.cyc >= READ_LATENCY)
                    else fail_text("R beat came before the read latency.");
            end
            if (i_r_ready) begin
                assert (o_r.id == er.r.id) else fail_value("o_r.id", o_r.id, er.r.id);
                assert (o_r.data == er.r.data) else fail_value("o_r.data", o_r.data, er.r.data);
                assert (o_r.resp == 2'b00) else fail_value("o_r.resp", o_r.resp, 2'b00);
                assert (o_r.last == er.r.last) else fail_value("o_r.last", o_r.last, er.r.last);
                void'(exp_r.pop_front());
            end
        end
        if (!i_reset && o_b_valid) begin
            assert (exp_b.size() != 0) else fail_text("B valid with no write outstanding.");
            eb = exp_b[0];
            assert (cycle - eb.cyc >= WRITE_LATENCY)
                else fail_text("B came before the write latency.");
            if (i_b_ready) begin
                assert (o_b.id == eb.id) else fail_value("o_b.id", o_b.id, eb.id);
                assert (o_b.resp == 2'b00) else fail_value("o_b.resp", o_b.resp, 2'b00);
                void'(exp_b.pop_front());
            end
        end
    end

    task automatic send_aw(input axi_a_t a);
        @(posedge clk);
        i_aw       <= a;
        i_aw_valid <= 1'b1;
        @(negedge clk);
        while (!o_aw_ready) @(negedge clk);
        @(posedge clk);
        i_aw_valid <= 1'b0;
    endtask

    task automatic send_ar(input axi_a_t a);
        logic [WORD_BITS-1:0] w;
        exp_r_t               e;
        @(posedge clk);
        i_ar       <= a;
        i_ar_valid <= 1'b1;
        @(negedge clk);
        while (!o_ar_ready) @(negedge clk);
        @(posedge clk);
        i_ar_valid <= 1'b0;
        w = a.addr[3 +: WORD_BITS];
        for (int i = 0; i <= int'(a.len); i++) begin
            e.r     = '{id: a.id, data: ref_mem[w], resp: 2'b00, last: (i == int'(a.len))};
            e.first = (i == 0);
            e.cyc   = cycle;    // Count at the AR edge.
            exp_r.push_back(e);
            if (a.burst == BURST_INCR) w = w + 1'b1;
        end
    endtask

    task automatic do_write(input axi_a_t a, input logic rand_strb, input logic fill);
        logic [WORD_BITS-1:0] w;
        logic [63:0]          d;
        logic [63:0]          s;
        exp_b_t               eb;
        send_aw(a);
        w = a.addr[3 +: WORD_BITS];
        for (int i = 0; i <= int'(a.len); i++) begin
            take_bits(64, d);
            s = 64'hFF;
            if (rand_strb) take_bits(8, s);
            if (fill) d = {~32'(w), 32'(w) ^ 32'hC3A5_0000};
            @(posedge clk);
            i_w       <= '{data: d, strb: s[7:0], last: (i == int'(a.len))};
            i_w_valid <= 1'b1;
            @(negedge clk);
            while (!o_w_ready) @(negedge clk);
            @(posedge clk);
            i_w_valid <= 1'b0;
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (s[b]) ref_mem[w][8*b +: 8] = d[8*b +: 8];
            end
            if (a.burst == BURST_INCR) w = w + 1'b1;
        end
        eb.id  = a.id;
        eb.cyc = cycle;
        exp_b.push_back(eb);
    endtask

    task automatic wait_reads();
        @(negedge clk);
        while (exp_r.size() != 0) @(negedge clk);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (exp_r.size() != 0 || exp_b.size() != 0) @(negedge clk);
    endtask

    task automatic check_reset();
        @(negedge clk);
        assert (!o_b_valid) else fail_value("o_b_valid", o_b_valid, 0);
        assert (!o_r_valid) else fail_value("o_r_valid", o_r_valid, 0);
        repeat (2) @(negedge clk);
        assert (o_aw_ready) else fail_value("o_aw_ready", o_aw_ready, 1);
        assert (o_ar_ready) else fail_value("o_ar_ready", o_ar_ready, 1);
    endtask

    task automatic test_incr_partial();
        do_write('{id: 4'h3, addr: 32'h100, len: 8'd3, burst: BURST_INCR}, 1'b1, 1'b0);
        wait_idle();
        send_ar('{id: 4'h5, addr: 32'h100, len: 8'd3, burst: BURST_INCR});
        wait_idle();
    endtask

    task automatic test_read_limit();
        r_hold = 1'b1;
        for (int i = 0; i < MAX_R_INFLIGHT; i++) begin
            send_ar('{id: 4'(i), addr: 32'(16 * i + 80), len: 8'd1, burst: BURST_INCR});
        end
        fork
            send_ar('{id: 4'h9, addr: 32'h200, len: 8'd2, burst: BURST_INCR});
            begin
                repeat (20) begin
                    @(negedge clk);
                    assert (!o_ar_ready) else fail_text("AR accepted beyond the read limit.");
                end
                r_hold = 1'b0;
            end
        join
        wait_idle();
    endtask

    task automatic test_fixed();
        do_write('{id: 4'h7, addr: 32'h200, len: 8'd3, burst: BURST_FIXED}, 1'b0, 1'b0);
        wait_idle();
        send_ar('{id: 4'h8, addr: 32'h200, len: 8'd2, burst: BURST_FIXED});
        wait_idle();
    endtask

    task automatic test_random();
        logic [63:0] v;
        axi_a_t      a;
        bp_on = 1'b1;
        repeat (40) begin
            take_bits(17, v);
            a.id    = v[3:0];
            a.len   = {5'd0, v[6:4]};
            a.addr  = {21'd0, v[14:7], 3'd0};
            a.burst = v[15] ? BURST_FIXED : BURST_INCR;
            if (v[16]) begin
                wait_reads();    // Reads in flight see the old data.
                do_write(a, 1'b1, 1'b0);
            end else begin
                send_ar(a);
            end
        end
        wait_idle();
        bp_on = 1'b0;
    endtask

    initial begin
        i_reset    = 1'b1;
        i_aw       = '0;
        i_aw_valid = 1'b0;
        i_w        = '0;
        i_w_valid  = 1'b0;
        i_ar       = '0;
        i_ar_valid = 1'b0;
        i_b_ready  = 1'b0;
        i_r_ready  = 1'b0;
        r_hold     = 1'b0;
        bp_on      = 1'b0;
        data_lfsr  = 16'd51270;
        ready_lfsr = 16'd51270;
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        check_reset();
        do_write('{id: 4'h0, addr: 32'h0, len: 8'd255, burst: BURST_INCR}, 1'b0, 1'b1);
        wait_idle();
        test_incr_partial();
        test_read_limit();
        test_fixed();
        test_random();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
